// ==== project.f ====
src/tile_pkg.sv
src/ctrl_pkg.sv
src/tile_cfg_if.sv
src/config_store.sv
src/const_regfile.sv
src/operand_xbar.sv
src/ldst_engine.sv
src/ldst_tile.sv
testbench/tb_clock_gen.sv
testbench/tb_ldst_tile.sv

// ==== src/config_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module config_store #(
    parameter int CFG_DEPTH = 8
) (
    input  wire                          clk_nop,
    input  wire                          rstn_s,
    input  wire                          i_start_exec,
    input  wire [$clog2(CFG_DEPTH)-1:0]  i_loop_end,
    input  wire                          i_cfg_wr,
    input  wire [$clog2(CFG_DEPTH)-1:0]  i_cfg_addr,
    input  wire ctrl_pkg::cfg_word_t     i_cfg_word,
    tile_cfg_if.src                      cfg
);
    import ctrl_pkg::*;

    localparam int PC_BITS = $clog2(CFG_DEPTH);

    // every selector on none, opcode nop
    localparam cfg_word_t CFG_IDLE = 40'h7777_00_0777;

    cfg_word_t           cfg_mem [CFG_DEPTH];
    logic [PC_BITS-1:0]  pc;
    cfg_word_t           cur;

    // ----------------------------------------
    // config memory, written only while idle
    // ----------------------------------------
    always_ff @(posedge clk_nop or negedge rstn_s) begin
        if (!rstn_s) begin
            for (int i = 0; i < CFG_DEPTH; i++) begin
                cfg_mem[i] <= CFG_IDLE;
            end
        end else if (i_cfg_wr && !i_start_exec) begin
            cfg_mem[i_cfg_addr] <= i_cfg_word;
        end
    end

    // program counter, held at 0 while idle
    always_ff @(posedge clk_nop or negedge rstn_s) begin
        if (!rstn_s) begin
            pc <= '0;
        end else if (!i_start_exec) begin
            pc <= '0;
        end else if (pc == i_loop_end) begin
            pc <= '0;
        end else begin
            pc <= pc + 1'b1;
        end
    end

    assign cur = cfg_mem[pc];

    // ----------------------------------------
    // field decode
    // ----------------------------------------
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            cfg.route_sel[n] = route_src_e'(cur.route[n][SEL_BITS-1:0]);
        end
        cfg.rhs_sel   = route_src_e'(cur.rhs_sel);
        cfg.lhs_sel   = route_src_e'(cur.lhs_sel);
        cfg.pred_sel  = route_src_e'(cur.pred_sel);
        cfg.opcode    = ldst_op_e'(cur.opcode);
        cfg.const_idx = cur.const_idx;
        cfg.pred_inv  = cur.pred_inv;
    end

    assign cfg.exec = i_start_exec;

endmodule

`default_nettype wire

// ==== src/const_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module const_regfile #(
    parameter int CONST_DEPTH = 8
) (
    input  wire                             clk_nop,
    input  wire                             rstn_s,
    input  wire                             i_start_exec,
    input  wire                             i_const_wr,
    input  wire [$clog2(CONST_DEPTH)-1:0]   i_const_addr,
    input  wire [tile_pkg::DATA_WIDTH-1:0]  i_const_data,
    input  wire [$clog2(CONST_DEPTH)-1:0]   i_const_idx,
    output logic [tile_pkg::DATA_WIDTH-1:0] o_const
);
    import tile_pkg::*;

    logic [DATA_WIDTH-1:0] const_regs [CONST_DEPTH];

    // loaded before execution starts
    always_ff @(posedge clk_nop or negedge rstn_s) begin
        if (!rstn_s) begin
            for (int i = 0; i < CONST_DEPTH; i++) begin
                const_regs[i] <= '0;
            end
        end else if (i_const_wr && !i_start_exec) begin
            const_regs[i_const_addr] <= i_const_data;
        end
    end

    // index comes from the current config entry
    assign o_const = const_regs[i_const_idx];

endmodule

`default_nettype wire

// ==== src/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // route selector width
    parameter int SEL_BITS = 3;

    // sources a selector can name
    typedef enum logic [SEL_BITS-1:0] {
        SRC_IN0     = 3'd0,
        SRC_IN1     = 3'd1,
        SRC_IN2     = 3'd2,
        SRC_IN3     = 3'd3,
        SRC_RESULT  = 3'd4,
        SRC_DELAYED = 3'd5,
        SRC_RSVD    = 3'd6,
        SRC_NONE    = 3'd7
    } route_src_e;

    // unlisted codes behave as nop
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_LOAD  = 3'd1,
        OP_STORE = 3'd3
    } ldst_op_e;

    // ----------------------------------------
    // 40-bit configuration word
    // ----------------------------------------
    // routing half on top, one nibble per neighbour output, selector in its low bits
    typedef struct packed {
        logic [3:0][3:0] route;
        logic [3:0]      rsvd_hi;
        logic            pred_inv;
        logic            rsvd_18;
        logic [2:0]      opcode;
        logic [2:0]      const_idx;
        logic            rsvd_11;
        logic [2:0]      pred_sel;
        logic            rsvd_7;
        logic [2:0]      lhs_sel;
        logic            rsvd_3;
        logic [2:0]      rhs_sel;
    } cfg_word_t;

endpackage

`default_nettype wire

// ==== src/ldst_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module ldst_engine #(
    parameter int DM_ADDR_BITS = 8
) (
    input  wire                             clk_nop,
    input  wire                             rstn_s,
    input  wire tile_pkg::flit_t            i_rhs,
    input  wire tile_pkg::flit_t            i_lhs,
    input  wire tile_pkg::flit_t            i_pred,
    input  wire [tile_pkg::DATA_WIDTH-1:0]  i_const,
    input  wire [tile_pkg::DM_WIDTH-1:0]    i_dm_rdata,
    output logic [DM_ADDR_BITS-1:0]         o_dm_addr,
    output logic [tile_pkg::DM_WIDTH-1:0]   o_dm_wdata,
    output logic [tile_pkg::DM_WIDTH-1:0]   o_dm_bit_en,
    output logic                            o_dm_rd_en_n,
    output logic                            o_dm_wr_en_n,
    output tile_pkg::flit_t                 o_result,
    output tile_pkg::flit_t                 o_delayed,
    tile_cfg_if.engine                      cfg
);
    import tile_pkg::*;
    import ctrl_pkg::*;

    logic                     is_load;
    logic                     is_store;
    logic                     pred_hit;
    logic                     pred_ok;
    logic                     do_exec;
    logic [DM_ADDR_BITS-1:0]  eff_addr;
    logic                     load_pend;
    flit_t                    result_q;
    flit_t                    delayed_q;

    // ----------------------------------------
    // execute decision
    // ----------------------------------------
    assign is_load  = (cfg.opcode == OP_LOAD);
    assign is_store = (cfg.opcode == OP_STORE);

    // valid predicate with nonzero data, optionally inverted
    assign pred_hit = (i_pred.valid && (|i_pred.data)) ^ cfg.pred_inv;

    // no predicate routed means always go
    assign pred_ok  = (cfg.pred_sel == SRC_NONE) || (cfg.pred_sel == SRC_RSVD) || pred_hit;

    assign do_exec  = cfg.exec && (is_load || is_store) && i_rhs.valid
                      && (!is_store || i_lhs.valid) && pred_ok;

    // base from rhs, offset from the constant file
    assign eff_addr = i_rhs.data[DM_ADDR_BITS-1:0] + i_const[DM_ADDR_BITS-1:0];

    // ----------------------------------------
    // memory port, same cycle as the decision
    // ----------------------------------------
    always_comb begin
        o_dm_rd_en_n = 1'b1;
        o_dm_wr_en_n = 1'b1;
        o_dm_addr    = '0;
        o_dm_wdata   = '0;
        o_dm_bit_en  = '0;
        if (do_exec) begin
            o_dm_addr = eff_addr;
            if (is_store) begin
                o_dm_wr_en_n = 1'b0;
                o_dm_wdata   = i_lhs.data;
                o_dm_bit_en  = '1;
            end else begin
                o_dm_rd_en_n = 1'b0;
            end
        end
    end

    // read data shows up one cycle after issue
    always_ff @(posedge clk_nop or negedge rstn_s) begin
        if (!rstn_s) begin
            load_pend <= 1'b0;
        end else begin
            load_pend <= do_exec && is_load;
        end
    end

    // result holds until the next executed load
    always_ff @(posedge clk_nop or negedge rstn_s) begin
        if (!rstn_s) begin
            result_q <= '0;
        end else if (load_pend) begin
            result_q.valid <= 1'b1;
            result_q.data  <= i_dm_rdata;
        end
    end

    // one-cycle copy of the result
    always_ff @(posedge clk_nop or negedge rstn_s) begin
        if (!rstn_s) begin
            delayed_q <= '0;
        end else if (cfg.exec) begin
            delayed_q <= result_q;
        end
    end

    assign o_result  = result_q;
    assign o_delayed = delayed_q;

endmodule

`default_nettype wire

// ==== src/ldst_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module ldst_tile #(
    parameter int CFG_DEPTH    = 8,
    parameter int CONST_DEPTH  = 8,
    parameter int DM_ADDR_BITS = 8
) (
    input  wire                             clk_nop,
    input  wire                             rstn_s,
    input  wire                             i_start_exec,
    input  wire [$clog2(CFG_DEPTH)-1:0]     i_loop_end,
    input  wire                             i_cfg_wr,
    input  wire [$clog2(CFG_DEPTH)-1:0]     i_cfg_addr,
    input  wire ctrl_pkg::cfg_word_t        i_cfg_word,
    input  wire                             i_const_wr,
    input  wire [$clog2(CONST_DEPTH)-1:0]   i_const_addr,
    input  wire [tile_pkg::DATA_WIDTH-1:0]  i_const_data,
    input  wire tile_pkg::flit_t            i_flit_in_0,
    input  wire tile_pkg::flit_t            i_flit_in_1,
    input  wire tile_pkg::flit_t            i_flit_in_2,
    input  wire tile_pkg::flit_t            i_flit_in_3,
    output tile_pkg::flit_t                 o_flit_out_0,
    output tile_pkg::flit_t                 o_flit_out_1,
    output tile_pkg::flit_t                 o_flit_out_2,
    output tile_pkg::flit_t                 o_flit_out_3,
    input  wire [tile_pkg::DM_WIDTH-1:0]    i_dm_rdata,
    output logic [DM_ADDR_BITS-1:0]         o_dm_addr,
    output logic [tile_pkg::DM_WIDTH-1:0]   o_dm_wdata,
    output logic [tile_pkg::DM_WIDTH-1:0]   o_dm_bit_en,
    output logic                            o_dm_rd_en_n,
    output logic                            o_dm_wr_en_n
);
    import tile_pkg::*;

    flit_t                 flit_in  [0:3];
    flit_t                 flit_out [0:3];
    flit_t                 op_rhs;
    flit_t                 op_lhs;
    flit_t                 op_pred;
    flit_t                 result;
    flit_t                 delayed;
    logic [DATA_WIDTH-1:0] const_val;

    // neighbour ports to arrays
    assign flit_in[0]   = i_flit_in_0;
    assign flit_in[1]   = i_flit_in_1;
    assign flit_in[2]   = i_flit_in_2;
    assign flit_in[3]   = i_flit_in_3;
    assign o_flit_out_0 = flit_out[0];
    assign o_flit_out_1 = flit_out[1];
    assign o_flit_out_2 = flit_out[2];
    assign o_flit_out_3 = flit_out[3];

    // decoded current entry
    tile_cfg_if #(.CONST_DEPTH(CONST_DEPTH)) cfg_bus ();

    config_store #(.CFG_DEPTH(CFG_DEPTH)) u_config_store (
        .clk_nop      (clk_nop),
        .rstn_s       (rstn_s),
        .i_start_exec (i_start_exec),
        .i_loop_end   (i_loop_end),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_word   (i_cfg_word),
        .cfg          (cfg_bus.src)
    );

    const_regfile #(.CONST_DEPTH(CONST_DEPTH)) u_const_regfile (
        .clk_nop      (clk_nop),
        .rstn_s       (rstn_s),
        .i_start_exec (i_start_exec),
        .i_const_wr   (i_const_wr),
        .i_const_addr (i_const_addr),
        .i_const_data (i_const_data),
        .i_const_idx  (cfg_bus.const_idx),
        .o_const      (const_val)
    );

    operand_xbar u_operand_xbar (
        .i_flit_in  (flit_in),
        .i_result   (result),
        .i_delayed  (delayed),
        .o_flit_out (flit_out),
        .o_rhs      (op_rhs),
        .o_lhs      (op_lhs),
        .o_pred     (op_pred),
        .cfg        (cfg_bus.xbar)
    );

    ldst_engine #(.DM_ADDR_BITS(DM_ADDR_BITS)) u_ldst_engine (
        .clk_nop      (clk_nop),
        .rstn_s       (rstn_s),
        .i_rhs        (op_rhs),
        .i_lhs        (op_lhs),
        .i_pred       (op_pred),
        .i_const      (const_val),
        .i_dm_rdata   (i_dm_rdata),
        .o_dm_addr    (o_dm_addr),
        .o_dm_wdata   (o_dm_wdata),
        .o_dm_bit_en  (o_dm_bit_en),
        .o_dm_rd_en_n (o_dm_rd_en_n),
        .o_dm_wr_en_n (o_dm_wr_en_n),
        .o_result     (result),
        .o_delayed    (delayed),
        .cfg          (cfg_bus.engine)
    );

endmodule

`default_nettype wire

// ==== src/operand_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_xbar (
    input  wire tile_pkg::flit_t  i_flit_in [0:3],
    input  wire tile_pkg::flit_t  i_result,
    input  wire tile_pkg::flit_t  i_delayed,
    output tile_pkg::flit_t       o_flit_out [0:3],
    output tile_pkg::flit_t       o_rhs,
    output tile_pkg::flit_t       o_lhs,
    output tile_pkg::flit_t       o_pred,
    tile_cfg_if.xbar              cfg
);
    import tile_pkg::*;
    import ctrl_pkg::*;

    localparam int NUM_SRC = 2 ** SEL_BITS;

    // one entry per selector code
    flit_t src_tbl [NUM_SRC];

    // ----------------------------------------
    // source table
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_tbl[i] = i_flit_in[i];
        end
        src_tbl[SRC_RESULT]  = i_result;
        src_tbl[SRC_DELAYED] = i_delayed;
        // code 6 behaves as none
        src_tbl[SRC_RSVD]    = '0;
        src_tbl[SRC_NONE]    = '0;
    end

    // ----------------------------------------
    // seven identical muxes
    // ----------------------------------------
    always_comb begin
        for (int o = 0; o < 4; o++) begin
            o_flit_out[o] = src_tbl[cfg.route_sel[o]];
        end
    end

    // operand slots for the engine
    assign o_rhs  = src_tbl[cfg.rhs_sel];
    assign o_lhs  = src_tbl[cfg.lhs_sel];
    assign o_pred = src_tbl[cfg.pred_sel];

endmodule

`default_nettype wire

// ==== src/tile_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tile_cfg_if #(
    parameter int CONST_DEPTH = 8
);
    import ctrl_pkg::*;

    localparam int IDX_BITS = $clog2(CONST_DEPTH);

    // routing for the four neighbour outputs
    route_src_e             route_sel [0:3];

    // operand slots
    route_src_e             rhs_sel;
    route_src_e             lhs_sel;
    route_src_e             pred_sel;

    ldst_op_e               opcode;
    logic [IDX_BITS-1:0]    const_idx;
    logic                   pred_inv;
    logic                   exec;

    modport src (
        output route_sel, rhs_sel, lhs_sel, pred_sel,
        output opcode, const_idx, pred_inv, exec
    );

    modport xbar (
        input route_sel, rhs_sel, lhs_sel, pred_sel
    );

    modport engine (
        input opcode, const_idx, pred_inv, exec, pred_sel
    );

endinterface

`default_nettype wire

// ==== src/tile_pkg.sv ====
`default_nettype none

package tile_pkg;

    // datapath word
    parameter int DATA_WIDTH = 16;

    // one data-memory word, same as the datapath here
    parameter int DM_WIDTH = 16;

    // valid sits above the data word, 17 bits in all
    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } flit_t;

endpackage

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk_nop,
    output logic o_rstn_s
);

    initial begin
        o_clk_nop = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk_nop = ~o_clk_nop;
        end
    end

    // low across the first few rising edges
    initial begin
        o_rstn_s = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk_nop);
        o_rstn_s <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_ldst_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ldst_tile;
    import tile_pkg::*;
    import ctrl_pkg::*;

    localparam int RESET_TIMEOUT  = 20;
    localparam int STROBE_TIMEOUT = 10;
    localparam int RESULT_TIMEOUT = 10;

    logic             clk_nop;
    logic             rstn_s;
    logic             i_start_exec;
    logic [2:0]       i_loop_end;
    logic             i_cfg_wr;
    logic [2:0]       i_cfg_addr;
    cfg_word_t        i_cfg_word;
    logic             i_const_wr;
    logic [2:0]       i_const_addr;
    logic [15:0]      i_const_data;
    flit_t            i_flit_in_0;
    flit_t            i_flit_in_1;
    flit_t            i_flit_in_2;
    flit_t            i_flit_in_3;
    flit_t            o_flit_out_0;
    flit_t            o_flit_out_1;
    flit_t            o_flit_out_2;
    flit_t            o_flit_out_3;
    logic [15:0]      i_dm_rdata;
    logic [7:0]       o_dm_addr;
    logic [15:0]      o_dm_wdata;
    logic [15:0]      o_dm_bit_en;
    logic             o_dm_rd_en_n;
    logic             o_dm_wr_en_n;

    int               errors;
    int               checks;
    bit               timed_out;
    logic [15:0]      lfsr_state;
    flit_t            in_now [0:3];
    logic [15:0]      dm_mem [0:255];
    logic [15:0]      st_rhs;
    logic [15:0]      st_const;
    logic [15:0]      st_wdata;
    logic [15:0]      p_wdata;
    logic [7:0]       st_addr;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clock_gen (
        .o_clk_nop (clk_nop),
        .o_rstn_s  (rstn_s)
    );

    ldst_tile i_ldst_tile (
        .clk_nop      (clk_nop),
        .rstn_s       (rstn_s),
        .i_start_exec (i_start_exec),
        .i_loop_end   (i_loop_end),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_word   (i_cfg_word),
        .i_const_wr   (i_const_wr),
        .i_const_addr (i_const_addr),
        .i_const_data (i_const_data),
        .i_flit_in_0  (i_flit_in_0),
        .i_flit_in_1  (i_flit_in_1),
        .i_flit_in_2  (i_flit_in_2),
        .i_flit_in_3  (i_flit_in_3),
        .o_flit_out_0 (o_flit_out_0),
        .o_flit_out_1 (o_flit_out_1),
        .o_flit_out_2 (o_flit_out_2),
        .o_flit_out_3 (o_flit_out_3),
        .i_dm_rdata   (i_dm_rdata),
        .o_dm_addr    (o_dm_addr),
        .o_dm_wdata   (o_dm_wdata),
        .o_dm_bit_en  (o_dm_bit_en),
        .o_dm_rd_en_n (o_dm_rd_en_n),
        .o_dm_wr_en_n (o_dm_wr_en_n)
    );

    // ----------------------------------------
    // data memory model with one cycle of read latency
    // ----------------------------------------
    initial begin
        for (int a = 0; a < 256; a++) begin
            dm_mem[a] = {a[7:0] ^ 8'hc3, ~a[7:0]};
        end
    end

    always @(posedge clk_nop) begin
        if (!o_dm_wr_en_n) begin
            dm_mem[o_dm_addr] <= (dm_mem[o_dm_addr] & ~o_dm_bit_en) | (o_dm_wdata & o_dm_bit_en);
        end
        if (!o_dm_rd_en_n) begin
            i_dm_rdata <= dm_mem[o_dm_addr];
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    task automatic random_flit(output flit_t f);
        logic [15:0] v;
        take_bits(1, v);
        f.valid = v[0];
        take_bits(16, v);
        f.data = v;
    endtask

    // field positions of the 40-bit config word
    function automatic logic [39:0] make_cfg(
        input logic [2:0] r0, input logic [2:0] r1, input logic [2:0] r2, input logic [2:0] r3,
        input logic [2:0] rhs, input logic [2:0] lhs, input logic [2:0] pred,
        input logic [2:0] cidx, input logic [2:0] op, input logic inv
    );
        logic [39:0] w;
        w = '0;
        w[2:0]   = rhs;
        w[6:4]   = lhs;
        w[10:8]  = pred;
        w[14:12] = cidx;
        w[17:15] = op;
        w[19]    = inv;
        w[26:24] = r0;
        w[30:28] = r1;
        w[34:32] = r2;
        w[38:36] = r3;
        return w;
    endfunction

    task automatic check_val(input string name, input logic [39:0] got, input logic [39:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_no_strobe();
        check_val("o_dm_rd_en_n", o_dm_rd_en_n, 40'h1);
        check_val("o_dm_wr_en_n", o_dm_wr_en_n, 40'h1);
    endtask

    task automatic apply_inputs();
        i_flit_in_0 <= in_now[0];
        i_flit_in_1 <= in_now[1];
        i_flit_in_2 <= in_now[2];
        i_flit_in_3 <= in_now[3];
    endtask

    task automatic clear_inputs();
        for (int i = 0; i < 4; i++) begin
            in_now[i] = '0;
        end
        apply_inputs();
    endtask

    task automatic write_cfg(input logic [2:0] addr, input logic [39:0] word);
        @(posedge clk_nop);
        i_cfg_wr   <= 1'b1;
        i_cfg_addr <= addr;
        i_cfg_word <= word;
        @(posedge clk_nop);
        i_cfg_wr   <= 1'b0;
    endtask

    task automatic write_const(input logic [2:0] addr, input logic [15:0] data);
        @(posedge clk_nop);
        i_const_wr   <= 1'b1;
        i_const_addr <= addr;
        i_const_data <= data;
        @(posedge clk_nop);
        i_const_wr   <= 1'b0;
    endtask

    // ----------------------------------------
    // bounded waits
    // ----------------------------------------
    task automatic wait_reset_release();
        int n;
        n = 0;
        @(posedge clk_nop);
        while (!rstn_s && n < RESET_TIMEOUT) begin
            @(posedge clk_nop);
            n++;
        end
        if (!rstn_s) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: reset was never released");
        end
    endtask

    // cycle count starts at 0 in the current cycle
    task automatic wait_strobe(output int cycles);
        cycles = 0;
        @(negedge clk_nop);
        while (o_dm_rd_en_n && o_dm_wr_en_n && cycles < STROBE_TIMEOUT) begin
            @(negedge clk_nop);
            cycles++;
        end
        if (o_dm_rd_en_n && o_dm_wr_en_n) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: no memory strobe after %0d cycles", cycles);
        end
    endtask

    // called right after the issue cycle ends
    task automatic wait_result(output int cycles);
        cycles = 1;
        @(negedge clk_nop);
        while (!o_flit_out_0.valid && cycles < RESULT_TIMEOUT) begin
            @(negedge clk_nop);
            cycles++;
        end
        if (!o_flit_out_0.valid) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: load result never became valid");
        end
    endtask

    // strobes and outputs stay quiet while reset is low
    always @(negedge clk_nop) begin
        if (!rstn_s) begin
            check_no_strobe();
            check_val("o_flit_out_0", o_flit_out_0, 40'h0);
            check_val("o_flit_out_1", o_flit_out_1, 40'h0);
            check_val("o_flit_out_2", o_flit_out_2, 40'h0);
            check_val("o_flit_out_3", o_flit_out_3, 40'h0);
        end
    end

    // ----------------------------------------
    // test phases
    // ----------------------------------------
    task automatic test_routing();
        write_cfg(3'd0, make_cfg(SRC_IN2, SRC_IN0, SRC_IN3, SRC_NONE,
                                 SRC_NONE, SRC_NONE, SRC_NONE, 3'd0, OP_NOP, 1'b0));
        repeat (6) begin
            @(posedge clk_nop);
            for (int i = 0; i < 4; i++) begin
                random_flit(in_now[i]);
            end
            apply_inputs();
            @(negedge clk_nop);
            check_val("o_flit_out_0", o_flit_out_0, in_now[2]);
            check_val("o_flit_out_1", o_flit_out_1, in_now[0]);
            check_val("o_flit_out_2", o_flit_out_2, in_now[3]);
            check_val("o_flit_out_3", o_flit_out_3, 40'h0);
            check_no_strobe();
        end
    endtask

    task automatic test_store();
        int cycles;
        take_bits(16, st_rhs);
        take_bits(16, st_const);
        take_bits(16, st_wdata);
        st_addr = st_rhs[7:0] + st_const[7:0];
        write_const(3'd2, st_const);
        write_cfg(3'd0, make_cfg(SRC_RESULT, SRC_DELAYED, SRC_IN2, SRC_NONE,
                                 SRC_IN0, SRC_IN1, SRC_NONE, 3'd2, OP_STORE, 1'b0));
        // nothing loaded yet
        @(negedge clk_nop);
        check_val("o_flit_out_0", o_flit_out_0, 40'h0);
        check_val("o_flit_out_1", o_flit_out_1, 40'h0);
        @(posedge clk_nop);
        in_now[0] = {1'b1, st_rhs};
        in_now[1] = {1'b1, st_wdata};
        apply_inputs();
        i_loop_end   <= 3'd0;
        i_start_exec <= 1'b1;
        wait_strobe(cycles);
        if (!timed_out) begin
            check_val("store strobe delay", cycles, 40'h0);
            check_val("o_dm_wr_en_n", o_dm_wr_en_n, 40'h0);
            check_val("o_dm_rd_en_n", o_dm_rd_en_n, 40'h1);
            check_val("o_dm_addr", o_dm_addr, st_addr);
            check_val("o_dm_wdata", o_dm_wdata, st_wdata);
            check_val("o_dm_bit_en", o_dm_bit_en, 40'hffff);
        end
        @(posedge clk_nop);
        i_start_exec <= 1'b0;
        clear_inputs();
    endtask

    task automatic test_load();
        int cycles;
        write_cfg(3'd0, make_cfg(SRC_RESULT, SRC_DELAYED, SRC_NONE, SRC_NONE,
                                 SRC_IN0, SRC_NONE, SRC_NONE, 3'd2, OP_LOAD, 1'b0));
        @(posedge clk_nop);
        in_now[0] = {1'b1, st_rhs};
        apply_inputs();
        i_start_exec <= 1'b1;
        wait_strobe(cycles);
        if (!timed_out) begin
            check_val("load strobe delay", cycles, 40'h0);
            check_val("o_dm_rd_en_n", o_dm_rd_en_n, 40'h0);
            check_val("o_dm_wr_en_n", o_dm_wr_en_n, 40'h1);
            check_val("o_dm_addr", o_dm_addr, st_addr);
            // single issue while exec stays on for the delayed copy
            @(posedge clk_nop);
            in_now[0].valid = 1'b0;
            apply_inputs();
            wait_result(cycles);
        end
        if (!timed_out) begin
            check_val("result latency", cycles, 40'h2);
            check_val("o_flit_out_0", o_flit_out_0, {1'b1, st_wdata});
            check_val("o_flit_out_1", o_flit_out_1, 40'h0);
            @(negedge clk_nop);
            check_val("o_flit_out_0", o_flit_out_0, {1'b1, st_wdata});
            check_val("o_flit_out_1", o_flit_out_1, {1'b1, st_wdata});
        end
        @(posedge clk_nop);
        i_start_exec <= 1'b0;
        clear_inputs();
    endtask

    task automatic test_predicate();
        int cycles;
        // invalid right operand
        write_cfg(3'd0, make_cfg(SRC_NONE, SRC_NONE, SRC_NONE, SRC_NONE,
                                 SRC_IN0, SRC_NONE, SRC_NONE, 3'd2, OP_LOAD, 1'b0));
        @(posedge clk_nop);
        in_now[0] = {1'b0, st_rhs};
        apply_inputs();
        i_start_exec <= 1'b1;
        repeat (3) begin
            @(negedge clk_nop);
            check_no_strobe();
        end
        @(posedge clk_nop);
        i_start_exec <= 1'b0;

        // predicate valid with zero data
        take_bits(16, p_wdata);
        write_cfg(3'd0, make_cfg(SRC_NONE, SRC_NONE, SRC_NONE, SRC_NONE,
                                 SRC_IN0, SRC_IN1, SRC_IN2, 3'd2, OP_STORE, 1'b0));
        @(posedge clk_nop);
        in_now[0] = {1'b1, st_rhs};
        in_now[1] = {1'b1, p_wdata};
        in_now[2] = {1'b1, 16'h0000};
        apply_inputs();
        i_start_exec <= 1'b1;
        repeat (3) begin
            @(negedge clk_nop);
            check_no_strobe();
        end
        @(posedge clk_nop);
        i_start_exec <= 1'b0;

        // same inputs with the predicate inverted
        write_cfg(3'd0, make_cfg(SRC_NONE, SRC_NONE, SRC_NONE, SRC_NONE,
                                 SRC_IN0, SRC_IN1, SRC_IN2, 3'd2, OP_STORE, 1'b1));
        @(posedge clk_nop);
        i_start_exec <= 1'b1;
        wait_strobe(cycles);
        if (!timed_out) begin
            check_val("inverted strobe delay", cycles, 40'h0);
            check_val("o_dm_wr_en_n", o_dm_wr_en_n, 40'h0);
            check_val("o_dm_addr", o_dm_addr, st_addr);
            check_val("o_dm_wdata", o_dm_wdata, p_wdata);
        end
        @(posedge clk_nop);
        i_start_exec <= 1'b0;
        clear_inputs();
    endtask

    task automatic test_pc();
        write_cfg(3'd0, make_cfg(SRC_IN0, SRC_IN1, SRC_IN2, SRC_IN3,
                                 SRC_NONE, SRC_NONE, SRC_NONE, 3'd0, OP_NOP, 1'b0));
        write_cfg(3'd1, make_cfg(SRC_IN3, SRC_IN2, SRC_IN1, SRC_IN0,
                                 SRC_NONE, SRC_NONE, SRC_NONE, 3'd0, OP_NOP, 1'b0));
        @(posedge clk_nop);
        for (int i = 0; i < 4; i++) begin
            random_flit(in_now[i]);
        end
        apply_inputs();
        i_loop_end   <= 3'd1;
        i_start_exec <= 1'b1;
        // entry 0 on even cycles and entry 1 on odd ones
        for (int k = 0; k < 8; k++) begin
            @(negedge clk_nop);
            if (k % 2 == 0) begin
                check_val("o_flit_out_0", o_flit_out_0, in_now[0]);
                check_val("o_flit_out_3", o_flit_out_3, in_now[3]);
            end else begin
                check_val("o_flit_out_0", o_flit_out_0, in_now[3]);
                check_val("o_flit_out_3", o_flit_out_3, in_now[0]);
            end
        end
        @(posedge clk_nop);
        i_start_exec <= 1'b0;
        i_loop_end   <= 3'd0;
        // back to entry 0 once idle
        @(negedge clk_nop);
        check_val("o_flit_out_0", o_flit_out_0, in_now[0]);
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        lfsr_state   = 16'd45275;
        i_start_exec = 1'b0;
        i_loop_end   = 3'd0;
        i_cfg_wr     = 1'b0;
        i_cfg_addr   = 3'd0;
        i_cfg_word   = '0;
        i_const_wr   = 1'b0;
        i_const_addr = 3'd0;
        i_const_data = 16'h0000;
        i_dm_rdata   = 16'h0000;
        // live neighbour traffic while reset is held
        for (int i = 0; i < 4; i++) begin
            random_flit(in_now[i]);
            in_now[i].valid = 1'b1;
        end
        i_flit_in_0  = in_now[0];
        i_flit_in_1  = in_now[1];
        i_flit_in_2  = in_now[2];
        i_flit_in_3  = in_now[3];

        wait_reset_release();
        if (!timed_out) begin
            @(negedge clk_nop);
            check_no_strobe();
            check_val("o_flit_out_0", o_flit_out_0, 40'h0);
            check_val("o_flit_out_1", o_flit_out_1, 40'h0);
            check_val("o_flit_out_2", o_flit_out_2, 40'h0);
            check_val("o_flit_out_3", o_flit_out_3, 40'h0);
        end
        if (!timed_out) begin
            test_routing();
        end
        if (!timed_out) begin
            test_store();
        end
        if (!timed_out) begin
            test_load();
        end
        if (!timed_out) begin
            test_predicate();
        end
        if (!timed_out) begin
            test_pc();
        end
        end_run();
    end

endmodule

`default_nettype wire
